// ==== xg_mac_pkg.sv ====
`default_nettype none

package xg_mac_pkg;

	//////////////////////////////////////////////////////////////////////
	// XGMII control characters

	localparam logic [7:0] xgmii_ctl_start = 8'hfb;
	localparam logic [7:0] xgmii_ctl_end   = 8'hfd;
	localparam logic [7:0] xgmii_ctl_error = 8'hfe;
	localparam logic [7:0] xgmii_ctl_idle  = 8'h07;

	// Second word of the preamble, ending in the SFD byte
	localparam logic [31:0] preamble_sfd = 32'h555555d5;

	//////////////////////////////////////////////////////////////////////
	// Widths and bus types

	localparam int xgmii_lanes      = 4;
	localparam int xgmii_data_width = 8 * xgmii_lanes;
	localparam int crc_width        = 32;

	// Lane 3 is the top byte and the first byte on the wire
	typedef logic [xgmii_lanes-1:0]      lane_mask_t;
	typedef logic [xgmii_data_width-1:0] xgmii_word_t;
	// Zero to four valid bytes
	typedef logic [2:0]                  bytes_valid_t;
	typedef logic [crc_width-1:0]        crc_t;

	//////////////////////////////////////////////////////////////////////
	// CRC-32 constants

	// Reflected form of the Ethernet polynomial
	localparam crc_t crc_poly = 32'hedb88320;
	localparam crc_t crc_init = 32'hffffffff;
	// Input register plus running value
	localparam int crc_latency = 2;

	//////////////////////////////////////////////////////////////////////
	// Receive FSM states

	typedef enum logic [1:0] {
		st_idle     = 2'd0,
		st_preamble = 2'd1,
		st_body     = 2'd2
	} rx_state_t;

endpackage

`default_nettype wire

// ==== xgmii_rx_decode.sv ====
`default_nettype none

module xgmii_rx_decode (
	input wire                      xgmii_rx_clk,
	input wire                      rst_n,
	input wire xg_mac_pkg::xgmii_word_t xgmii_rxd,
	input wire xg_mac_pkg::lane_mask_t  xgmii_rxc,
	output xg_mac_pkg::xgmii_word_t     rx_data,
	output xg_mac_pkg::lane_mask_t      lane_end,
	output xg_mac_pkg::lane_mask_t      lane_err,
	output logic                        sof_seen,
	output logic                        preamble_ok
);

	import xg_mac_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Per-lane control decode

	// Flags look at the word on the bus right now
	// A lane only counts when its control bit is set
	always_comb begin
		for (int i = 0; i < xgmii_lanes; i++) begin
			lane_end[i] = xgmii_rxc[i] && (xgmii_rxd[i*8 +: 8] == xgmii_ctl_end);
			lane_err[i] = xgmii_rxc[i] && (xgmii_rxd[i*8 +: 8] == xgmii_ctl_error);
		end
	end

	// Start is only legal in the leftmost lane
	assign sof_seen = xgmii_rxc[3] && (xgmii_rxd[31:24] == xgmii_ctl_start);

	// Preamble word is all data, 55 55 55 D5
	assign preamble_ok = (xgmii_rxc == '0) && (xgmii_rxd == preamble_sfd);

	//////////////////////////////////////////////////////////////////////
	// Word delay

	// Downstream sees this word next to the one still on the bus,
	// which lets it split the FCS across two words
	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_data <= '0;
		end else begin
			rx_data <= xgmii_rxd;
		end
	end

endmodule

`default_nettype wire

// ==== rx_fcs_extract.sv ====
`default_nettype none

module rx_fcs_extract (
	input wire                          xgmii_rx_clk,
	input wire                          rst_n,
	input wire xg_mac_pkg::xgmii_word_t rx_data,
	input wire xg_mac_pkg::xgmii_word_t xgmii_rxd,
	input wire xg_mac_pkg::lane_mask_t  lane_end,
	output xg_mac_pkg::crc_t            fcs_expected
);

	import xg_mac_pkg::*;

	crc_t fcs_now;
	crc_t fcs_pipe [crc_latency];

	//////////////////////////////////////////////////////////////////////
	// FCS position from terminate lane

	// The four bytes before the terminate are the FCS
	// They start in the previous word and may run into the current one
	always_comb begin
		if (lane_end[3]) begin
			fcs_now = rx_data;
		end else if (lane_end[2]) begin
			fcs_now = {rx_data[23:0], xgmii_rxd[31:24]};
		end else if (lane_end[1]) begin
			fcs_now = {rx_data[15:0], xgmii_rxd[31:16]};
		end else if (lane_end[0]) begin
			fcs_now = {rx_data[7:0], xgmii_rxd[31:8]};
		end else begin
			// No terminate, value is never sampled
			fcs_now = rx_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Delay line

	// Same depth as the CRC engine so both arrive together
	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < crc_latency; i++) begin
				fcs_pipe[i] <= '0;
			end
		end else begin
			fcs_pipe[0] <= fcs_now;
			for (int i = 1; i < crc_latency; i++) begin
				fcs_pipe[i] <= fcs_pipe[i-1];
			end
		end
	end

	assign fcs_expected = fcs_pipe[crc_latency-1];

endmodule

`default_nettype wire

// ==== crc32_x32_var.sv ====
`default_nettype none

module crc32_x32_var (
	input wire                           xgmii_rx_clk,
	input wire                           rst_n,
	input wire                           crc_restart,
	input wire xg_mac_pkg::bytes_valid_t crc_len,
	input wire xg_mac_pkg::xgmii_word_t  crc_data,
	output xg_mac_pkg::crc_t             crc_value
);

	import xg_mac_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Bitwise update

	// One byte, LSB first as it goes out on the wire
	function automatic crc_t crc_byte(input crc_t crc_in, input logic [7:0] b);
		crc_t c;
		c = crc_in;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ b[i]) begin
				c = (c >> 1) ^ crc_poly;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	// Top byte first, stop after len bytes
	function automatic crc_t crc_word(
		input crc_t         crc_in,
		input xgmii_word_t  d,
		input bytes_valid_t len
	);
		crc_t c;
		c = crc_in;
		for (int k = 0; k < xgmii_lanes; k++) begin
			if (k < int'(len)) begin
				c = crc_byte(c, d[xgmii_data_width-1-8*k -: 8]);
			end
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stage 1 input register

	logic         restart_ff;
	bytes_valid_t len_ff;
	xgmii_word_t  din_ff;

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			restart_ff <= 1'b0;
			len_ff     <= '0;
			din_ff     <= '0;
		end else begin
			restart_ff <= crc_restart;
			len_ff     <= crc_len;
			din_ff     <= crc_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 2 running value

	crc_t crc_state;
	crc_t crc_final;

	// Restart seeds from init and still folds in that cycle's bytes
	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_state <= crc_init;
		end else begin
			crc_state <= crc_word(restart_ff ? crc_init : crc_state, din_ff, len_ff);
		end
	end

	assign crc_final = ~crc_state;

	// Byte swap so the result matches FCS in bus order, first wire byte on top
	assign crc_value = {crc_final[7:0], crc_final[15:8], crc_final[23:16], crc_final[31:24]};

endmodule

`default_nettype wire

// ==== rx_frame_fsm.sv ====
`default_nettype none

module rx_frame_fsm (
	input wire                          xgmii_rx_clk,
	input wire                          rst_n,
	input wire xg_mac_pkg::xgmii_word_t rx_data,
	input wire xg_mac_pkg::lane_mask_t  lane_end,
	input wire xg_mac_pkg::lane_mask_t  lane_err,
	input wire                          sof_seen,
	input wire                          preamble_ok,
	input wire xg_mac_pkg::crc_t        fcs_expected,
	input wire xg_mac_pkg::crc_t        crc_value,
	output logic                        start,
	output logic                        data_valid,
	output xg_mac_pkg::bytes_valid_t    bytes_valid,
	output logic                        commit,
	output logic                        drop,
	output logic                        crc_restart,
	output xg_mac_pkg::bytes_valid_t    crc_len
);

	import xg_mac_pkg::*;

	rx_state_t state;
	logic      fcs_pending_0;
	logic      fcs_pending_1;
	logic      holds_preamble;

	//////////////////////////////////////////////////////////////////////
	// Upper-layer stream

	// First body cycle still shows the SFD word on rx_data
	assign holds_preamble = start && (rx_data == preamble_sfd);

	// One word held back, the current bus word decides if rx_data is FCS
	always_comb begin
		data_valid  = 1'b0;
		bytes_valid = 3'd0;
		if (state == st_body) begin
			if (lane_end[3]) begin
				// Whole held word is FCS
				bytes_valid = 3'd0;
			end else if (lane_end[2]) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd1;
			end else if (lane_end[1]) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd2;
			end else if (lane_end[0]) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd3;
			end else if (!holds_preamble) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd4;
			end
		end
	end

	// CRC sees exactly the bytes handed upward
	assign crc_restart = start;
	assign crc_len     = bytes_valid;

	//////////////////////////////////////////////////////////////////////
	// Frame FSM

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= st_idle;
			start         <= 1'b0;
			commit        <= 1'b0;
			drop          <= 1'b0;
			fcs_pending_0 <= 1'b0;
			fcs_pending_1 <= 1'b0;
		end else begin
			start         <= 1'b0;
			commit        <= 1'b0;
			drop          <= 1'b0;
			fcs_pending_0 <= 1'b0;
			fcs_pending_1 <= fcs_pending_0;

			// Verdict two cycles after terminate, lined up with CRC output
			if (fcs_pending_1) begin
				if (fcs_expected == crc_value) begin
					commit <= 1'b1;
				end else begin
					drop <= 1'b1;
				end
			end

			case (state)
				st_idle: begin
					if (sof_seen) begin
						state <= st_preamble;
					end
				end
				// Exactly one preamble word allowed
				st_preamble: begin
					if (preamble_ok) begin
						state <= st_body;
						start <= 1'b1;
					end else begin
						state <= st_idle;
					end
				end
				// Terminate may land in any lane
				st_body: begin
					if (|lane_end) begin
						fcs_pending_0 <= 1'b1;
						state         <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase

			// Error mid-frame wins over everything above
			if ((|lane_err) && (state != st_idle)) begin
				state         <= st_idle;
				drop          <= 1'b1;
				fcs_pending_0 <= 1'b0;
				fcs_pending_1 <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== xg_mac_rx.sv ====
`default_nettype none

module xg_mac_rx (
	input wire                          xgmii_rx_clk,
	input wire                          rst_n,
	input wire xg_mac_pkg::xgmii_word_t xgmii_rxd,
	input wire xg_mac_pkg::lane_mask_t  xgmii_rxc,
	output wire xg_mac_pkg::xgmii_word_t rx_data,
	output wire                         start,
	output wire                         data_valid,
	output wire xg_mac_pkg::bytes_valid_t bytes_valid,
	output wire                         commit,
	output wire                         drop
);

	import xg_mac_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Internal nets

	wire lane_mask_t   lane_end;
	wire lane_mask_t   lane_err;
	wire               sof_seen;
	wire               preamble_ok;
	wire crc_t         fcs_expected;
	wire crc_t         crc_value;
	wire               crc_restart;
	wire bytes_valid_t crc_len;

	// Control decode and one-word delay
	xgmii_rx_decode u_decode (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.xgmii_rxd    (xgmii_rxd),
		.xgmii_rxc    (xgmii_rxc),
		.rx_data      (rx_data),
		.lane_end     (lane_end),
		.lane_err     (lane_err),
		.sof_seen     (sof_seen),
		.preamble_ok  (preamble_ok)
	);

	// Expected FCS, aligned to the CRC
	rx_fcs_extract u_fcs (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.rx_data      (rx_data),
		.xgmii_rxd    (xgmii_rxd),
		.lane_end     (lane_end),
		.fcs_expected (fcs_expected)
	);

	// Runs over the same words the upper layer sees
	crc32_x32_var u_crc (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.crc_restart  (crc_restart),
		.crc_len      (crc_len),
		.crc_data     (rx_data),
		.crc_value    (crc_value)
	);

	rx_frame_fsm u_fsm (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.rx_data      (rx_data),
		.lane_end     (lane_end),
		.lane_err     (lane_err),
		.sof_seen     (sof_seen),
		.preamble_ok  (preamble_ok),
		.fcs_expected (fcs_expected),
		.crc_value    (crc_value),
		.start        (start),
		.data_valid   (data_valid),
		.bytes_valid  (bytes_valid),
		.commit       (commit),
		.drop         (drop),
		.crc_restart  (crc_restart),
		.crc_len      (crc_len)
	);

endmodule

`default_nettype wire

// ==== tb_xg_mac_rx.sv ====
`default_nettype none

module tb_xg_mac_rx;

	import xg_mac_pkg::*;

	// One event mask bit per strobe
	localparam logic [2:0] ev_start  = 3'b001;
	localparam logic [2:0] ev_commit = 3'b010;
	localparam logic [2:0] ev_drop   = 3'b100;

	localparam int kind_good    = 0;
	localparam int kind_bad_fcs = 1;
	localparam int kind_error   = 2;
	localparam int kind_bad_pre = 3;

	// Fifteen frames of at most 200 bytes plus overhead and a gap of 4 idles
	localparam int n_frames         = 15;
	localparam int max_frame_cycles = 64;
	localparam int timeout_cycles   = n_frames * max_frame_cycles + 200;

	logic        xgmii_rx_clk = 1'b0;
	logic        rst_n;
	xgmii_word_t xgmii_rxd;
	lane_mask_t  xgmii_rxc;
	xgmii_word_t rx_data;
	logic        start;
	logic        data_valid;
	bytes_valid_t bytes_valid;
	logic        commit;
	logic        drop;

	integer      seed;
	int          cyc = 0;
	int          value_errors = 0;
	int          other_errors = 0;
	string       test_name;
	logic [2:0]  exp_at [int];
	logic [7:0]  exp_bytes [$];
	logic [7:0]  got_bytes [$];
	int          frame_len [4];

	xg_mac_rx uut (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.xgmii_rxd    (xgmii_rxd),
		.xgmii_rxc    (xgmii_rxc),
		.rx_data      (rx_data),
		.start        (start),
		.data_valid   (data_valid),
		.bytes_valid  (bytes_valid),
		.commit       (commit),
		.drop         (drop)
	);

	always #5 xgmii_rx_clk = ~xgmii_rx_clk;

	// Cycle number of the word on the bus
	always @(posedge xgmii_rx_clk) cyc <= cyc + 1;

	////////////////////////////////////////////////////////////////////
	// Reference model

	// Reflected Ethernet CRC-32 computed one byte at a time
	function automatic logic [31:0] ref_crc(input logic [7:0] data [$]);
		logic [31:0] c;
		c = 32'hffffffff;
		foreach (data[i]) begin
			c = c ^ {24'd0, data[i]};
			for (int b = 0; b < 8; b++) begin
				c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
			end
		end
		return ~c;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic void expect_event(input int c, input logic [2:0] m);
		if (exp_at.exists(c)) exp_at[c] = exp_at[c] | m;
		else exp_at[c] = m;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic drive_word(input xgmii_word_t d, input lane_mask_t c);
		@(posedge xgmii_rx_clk);
		#1;
		xgmii_rxd = d;
		xgmii_rxc = c;
	endtask

	task automatic drive_idles(input int n);
		repeat (n) drive_word({4{xgmii_ctl_idle}}, 4'hf);
	endtask

	// Lane entries hold {control bit, byte} in wire order
	task automatic send_frame(input int len, input int kind, input int gap);
		logic [7:0]  pay [$];
		logic [8:0]  lane_q [$];
		logic [31:0] fcs;
		int          s;
		int          w_e;
		int          term;
		for (int i = 0; i < len; i++) pay.push_back(8'($random(seed)));
		fcs = ref_crc(pay);
		if (kind == kind_bad_fcs) fcs = fcs ^ (32'd1 << rand_range(0, 31));
		lane_q.push_back({1'b1, xgmii_ctl_start});
		repeat (6) lane_q.push_back({1'b0, 8'h55});
		lane_q.push_back({1'b0, (kind == kind_bad_pre) ? 8'h5d : 8'hd5});
		foreach (pay[i]) lane_q.push_back({1'b0, pay[i]});
		// FCS goes out low byte first
		lane_q.push_back({1'b0, fcs[7:0]});
		lane_q.push_back({1'b0, fcs[15:8]});
		lane_q.push_back({1'b0, fcs[23:16]});
		lane_q.push_back({1'b0, fcs[31:24]});
		lane_q.push_back({1'b1, xgmii_ctl_end});
		while (lane_q.size() % 4 != 0) lane_q.push_back({1'b1, xgmii_ctl_idle});
		// Error lands in a body word made only of payload
		w_e = rand_range(1, len / 4 - 2);
		if (kind == kind_error) begin
			lane_q[4 * (2 + w_e) + rand_range(0, 3)] = {1'b1, xgmii_ctl_error};
		end
		// Error frames deliver only the words before the error
		if (kind == kind_good || kind == kind_bad_fcs) begin
			foreach (pay[i]) exp_bytes.push_back(pay[i]);
		end else if (kind == kind_error) begin
			for (int i = 0; i < 4 * w_e; i++) exp_bytes.push_back(pay[i]);
		end
		term = (len + 12) / 4;
		for (int w = 0; w < lane_q.size() / 4; w++) begin
			drive_word({lane_q[4*w][7:0], lane_q[4*w+1][7:0], lane_q[4*w+2][7:0],
				lane_q[4*w+3][7:0]},
				{lane_q[4*w][8], lane_q[4*w+1][8], lane_q[4*w+2][8], lane_q[4*w+3][8]});
			if (w == 0) begin
				s = cyc;
				if (kind != kind_bad_pre) expect_event(s + 2, ev_start);
				if (kind == kind_good) expect_event(s + term + 3, ev_commit);
				if (kind == kind_bad_fcs) expect_event(s + term + 3, ev_drop);
				if (kind == kind_error) expect_event(s + 2 + w_e + 1, ev_drop);
			end
		end
		drive_idles(gap);
	endtask

	task automatic check_quiet();
		assert (!start && !data_valid && !commit && !drop && bytes_valid == 3'd0) else begin
			value_errors++;
			$display("CHECK FAILED %s: expected 0, actual %b%b%b%b bytes_valid %0d",
				test_name, start, data_valid, commit, drop, bytes_valid);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Collector and comparator

	// Valid bytes are collected in wire order from the top lane down
	always @(negedge xgmii_rx_clk) begin
		if (rst_n && data_valid) begin
			for (int k = 0; k < 4; k++) begin
				if (k < int'(bytes_valid)) got_bytes.push_back(rx_data[31-8*k -: 8]);
			end
		end
	end

	// Strobes must match the expected mask on every cycle
	always @(negedge xgmii_rx_clk) begin
		logic [2:0] want;
		logic [7:0] g;
		logic [7:0] e;
		want = exp_at.exists(cyc) ? exp_at[cyc] : 3'd0;
		if (exp_at.exists(cyc)) exp_at.delete(cyc);
		assert ({drop, commit, start} == want) else begin
			value_errors++;
			$display("CHECK FAILED %s: expected drop/commit/start %b, actual %b at cycle %0d",
				test_name, want, {drop, commit, start}, cyc);
		end
		while (got_bytes.size() > 0) begin
			g = got_bytes.pop_front();
			assert (exp_bytes.size() > 0) else begin
				other_errors++;
				$display("ERROR %s: byte %02h delivered where no payload was due", test_name, g);
			end
			if (exp_bytes.size() > 0) begin
				e = exp_bytes.pop_front();
				assert (g == e) else begin
					value_errors++;
					$display("CHECK FAILED %s: expected %02h, actual %02h", test_name, e, g);
				end
			end
		end
	end

	initial begin
		#(timeout_cycles * 10);
		$display("ERROR: watchdog ran out of time before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed      = 73863;
		rst_n     = 1'b0;
		xgmii_rxd = {4{xgmii_ctl_idle}};
		xgmii_rxc = 4'hf;
		test_name = "reset";
		repeat (8) begin
			@(negedge xgmii_rx_clk);
			check_quiet();
		end
		@(posedge xgmii_rx_clk);
		#1 rst_n = 1'b1;
		repeat (2) begin
			@(negedge xgmii_rx_clk);
			check_quiet();
		end
		drive_idles(2);

		// Length mod 4 walks the terminate through all lanes
		test_name = "good_frame";
		for (int r = 0; r < 4; r++) begin
			frame_len[r] = 48 + 4 * rand_range(0, 37) + r;
			send_frame(frame_len[r], kind_good, 4);
		end
		test_name = "bad_fcs";
		for (int r = 0; r < 4; r++) send_frame(frame_len[r], kind_bad_fcs, 4);
		test_name = "error_char";
		repeat (2) send_frame(rand_range(46, 200), kind_error, 4);
		test_name = "bad_preamble";
		send_frame(rand_range(46, 200), kind_bad_pre, 4);
		// One idle word between frames
		test_name = "back_to_back";
		for (int r = 0; r < 4; r++) send_frame(46 + r + 4 * rand_range(0, 37), kind_good, 1);
		drive_idles(12);

		test_name = "final";
		assert (exp_bytes.size() == 0) else begin
			other_errors++;
			$display("ERROR: %0d payload bytes were never delivered", exp_bytes.size());
		end
		assert (exp_at.num() == 0) else begin
			other_errors++;
			$display("ERROR: %0d expected strobe cycles were never reached", exp_at.num());
		end
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
xg_mac_pkg.sv
xgmii_rx_decode.sv
rx_fcs_extract.sv
crc32_x32_var.sv
rx_frame_fsm.sv
xg_mac_rx.sv
tb_xg_mac_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the XGMII receive testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module tb_xg_mac_rx -f sources.f \
	-o tb_xg_mac_rx_sim > build.log 2>&1 \
	&& ./obj_dir/tb_xg_mac_rx_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
